// ==== logic/dla_pkg.sv ====
package dla_pkg;

    //////////////////////////////////////////////////////////////////////
    // Field widths
    //////////////////////////////////////////////////////////////////////

    // Tile dimensions and the row/col position inside a tile
    localparam int DIM_WID   = 6;

    // Beats per pixel
    localparam int DEPTH_WID = 4;

    localparam int SHIFT_WID = 5;

    // Global output buffer addressing
    localparam int ADDR_WID  = 16;

    //////////////////////////////////////////////////////////////////////
    // Structs
    //////////////////////////////////////////////////////////////////////

    // Latched once per tile
    typedef struct packed {
        logic [DIM_WID-1:0]   tile_length;
        logic [DIM_WID-1:0]   tile_height;
        logic [DEPTH_WID-1:0] valid_num;
        logic [SHIFT_WID-1:0] qtf_shift;
    } tile_cfg_t;

    // Output pixel position
    typedef struct packed {
        logic [DIM_WID-1:0] row;
        logic [DIM_WID-1:0] col;
        logic               tile_last;
    } pixel_pos_t;

    // Beat control, travels down the MAC pipeline with the data
    typedef struct packed {
        logic       valid;
        logic       first;
        logic       last;
        pixel_pos_t pos;
    } mac_cmd_t;

endpackage

// ==== logic/tile_sequencer.sv ====
`timescale 1ns/100ps

module tile_sequencer import dla_pkg::*; #(
    parameter int SIZE     = 8,
    parameter int DATA_WID = 16
) (
    input  logic                          clock,
    input  logic                          rst,

    input  logic                          tile_start,
    input  logic [DIM_WID-1:0]            tile_length,
    input  logic [DIM_WID-1:0]            tile_height,
    input  logic [DEPTH_WID-1:0]          valid_num,
    input  logic [SHIFT_WID-1:0]          qtf_shift,

    input  logic                          beat_valid,
    input  logic signed [DATA_WID-1:0]    ifm_pixel,
    input  logic [SIZE-1:0][DATA_WID-1:0] wgt_vec,

    output logic                          busy,
    output tile_cfg_t                     cfg,
    output mac_cmd_t                      cmd,
    output logic signed [DATA_WID-1:0]    cmd_pixel,
    output logic [SIZE-1:0][DATA_WID-1:0] cmd_wgt
);

    logic [DEPTH_WID-1:0] beat_cnt;
    logic [DIM_WID-1:0]   col_cnt;
    logic [DIM_WID-1:0]   row_cnt;

    logic accept;
    logic beat_first;
    logic beat_last;
    logic col_last;
    logic row_last;

    // Beats outside a tile are dropped
    assign accept     = busy && beat_valid;
    assign beat_first = (beat_cnt == '0);
    assign beat_last  = (beat_cnt == cfg.valid_num - DEPTH_WID'(1));
    assign col_last   = (col_cnt == cfg.tile_length - DIM_WID'(1));
    assign row_last   = (row_cnt == cfg.tile_height - DIM_WID'(1));

    //////////////////////////////////////////////////////////////////////
    // Beat, column and row counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            busy     <= 1'b0;
            cfg      <= '0;
            beat_cnt <= '0;
            col_cnt  <= '0;
            row_cnt  <= '0;
        end else if (!busy) begin
            if (tile_start) begin
                busy            <= 1'b1;
                cfg.tile_length <= tile_length;
                cfg.tile_height <= tile_height;
                cfg.valid_num   <= valid_num;
                // Shared by every stage, so only change it on a drained pipe
                cfg.qtf_shift   <= qtf_shift;
                beat_cnt        <= '0;
                col_cnt         <= '0;
                row_cnt         <= '0;
            end
        end else if (accept) begin
            if (!beat_last) begin
                beat_cnt <= beat_cnt + DEPTH_WID'(1);
            end else begin
                beat_cnt <= '0;
                if (!col_last) begin
                    col_cnt <= col_cnt + DIM_WID'(1);
                end else begin
                    col_cnt <= '0;
                    if (!row_last) begin
                        row_cnt <= row_cnt + DIM_WID'(1);
                    end else begin
                        // Final beat of the tile
                        row_cnt <= '0;
                        busy    <= 1'b0;
                    end
                end
            end
        end
    end

    // Tag the accepted beat
    always_ff @(posedge clock) begin
        if (rst) begin
            cmd <= '0;
        end else begin
            cmd.valid <= accept;
            if (accept) begin
                cmd.first         <= beat_first;
                cmd.last          <= beat_last;
                cmd.pos.row       <= row_cnt;
                cmd.pos.col       <= col_cnt;
                cmd.pos.tile_last <= col_last && row_last;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            cmd_pixel <= ifm_pixel;
            cmd_wgt   <= wgt_vec;
        end
    end

endmodule

// ==== logic/mac_row.sv ====
`timescale 1ns/100ps

module mac_row import dla_pkg::*; #(
    parameter int SIZE     = 8,
    parameter int DATA_WID = 16,
    parameter int ACC_WID  = 40
) (
    input  logic                          clock,
    input  logic                          rst,

    input  mac_cmd_t                      cmd,
    input  logic signed [DATA_WID-1:0]    cmd_pixel,
    input  logic [SIZE-1:0][DATA_WID-1:0] cmd_wgt,

    output logic                          psum_valid,
    output logic [SIZE-1:0][ACC_WID-1:0]  psum_vec,
    output pixel_pos_t                    psum_pos
);

    mac_cmd_t                          prod_cmd;
    logic [SIZE-1:0][2*DATA_WID-1:0]   prod;

    //////////////////////////////////////////////////////////////////////
    // Stage 1, one product per output channel
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            prod_cmd <= '0;
        end else begin
            prod_cmd <= cmd;
        end
    end

    always_ff @(posedge clock) begin
        if (cmd.valid) begin
            for (int i = 0; i < SIZE; i++) begin
                prod[i] <= cmd_pixel * $signed(cmd_wgt[i]);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2, accumulate over the pixel's beats
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            psum_valid <= 1'b0;
        end else begin
            psum_valid <= prod_cmd.valid && prod_cmd.last;
        end
    end

    // The sums stay put for one cycle after the last beat, long enough
    // for qtf_unit to take them before the next pixel's first beat lands
    always_ff @(posedge clock) begin
        if (prod_cmd.valid) begin
            for (int i = 0; i < SIZE; i++) begin
                if (prod_cmd.first) begin
                    psum_vec[i] <= ACC_WID'($signed(prod[i]));
                end else begin
                    psum_vec[i] <= psum_vec[i] + ACC_WID'($signed(prod[i]));
                end
            end
            psum_pos <= prod_cmd.pos;
        end
    end

endmodule

// ==== logic/qtf_unit.sv ====
`timescale 1ns/100ps

module qtf_unit import dla_pkg::*; #(
    parameter int SIZE     = 8,
    parameter int DATA_WID = 16,
    parameter int ACC_WID  = 40
) (
    input  logic                          clock,
    input  logic                          rst,

    input  logic [SHIFT_WID-1:0]          qtf_shift,
    input  logic [SIZE-1:0][DATA_WID-1:0] bias,

    input  logic                          psum_valid,
    input  logic [SIZE-1:0][ACC_WID-1:0]  psum_vec,
    input  pixel_pos_t                    psum_pos,

    output logic                          q_valid,
    output logic [SIZE-1:0][DATA_WID-1:0] q_vec,
    output pixel_pos_t                    q_pos
);

    // Bias, floor shift, then clamp to the signed lane range
    function automatic logic [DATA_WID-1:0] quantize(
        input logic [ACC_WID-1:0]   psum,
        input logic [DATA_WID-1:0]  b,
        input logic [SHIFT_WID-1:0] sh
    );
        logic signed [ACC_WID:0]      sum;
        logic signed [ACC_WID:0]      shifted;
        logic [ACC_WID-DATA_WID+1:0]  upper;
        sum     = (ACC_WID+1)'($signed(psum)) + (ACC_WID+1)'($signed(b));
        shifted = sum >>> sh;
        // Fits when everything above the lane's sign bit repeats it
        upper   = shifted[ACC_WID:DATA_WID-1];
        if (&upper || ~|upper) begin
            return shifted[DATA_WID-1:0];
        end else if (shifted[ACC_WID]) begin
            return {1'b1, {(DATA_WID-1){1'b0}}};
        end else begin
            return {1'b0, {(DATA_WID-1){1'b1}}};
        end
    endfunction

    always_ff @(posedge clock) begin
        if (rst) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= psum_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (psum_valid) begin
            for (int i = 0; i < SIZE; i++) begin
                q_vec[i] <= quantize(psum_vec[i], bias[i], qtf_shift);
            end
            q_pos <= psum_pos;
        end
    end

endmodule

// ==== logic/glb_writer.sv ====
`timescale 1ns/100ps

module glb_writer import dla_pkg::*; #(
    parameter int SIZE     = 8,
    parameter int DATA_WID = 16
) (
    input  logic                          clock,
    input  logic                          rst,

    input  logic [ADDR_WID-1:0]           of_base_addr,
    input  logic [ADDR_WID-1:0]           of_page_length,

    input  logic                          q_valid,
    input  logic [SIZE-1:0][DATA_WID-1:0] q_vec,
    input  pixel_pos_t                    q_pos,

    output logic                          of_wr_en,
    output logic [ADDR_WID-1:0]           of_wr_addr,
    output logic [SIZE-1:0][DATA_WID-1:0] of_wr_data,
    output logic                          tile_done
);

    logic [ADDR_WID-1:0] row_offset;
    logic [ADDR_WID-1:0] pixel_addr;

    // Row-major, one page per tile row
    assign row_offset = ADDR_WID'(q_pos.row) * of_page_length;
    assign pixel_addr = of_base_addr + row_offset + ADDR_WID'(q_pos.col);

    always_ff @(posedge clock) begin
        if (rst) begin
            of_wr_en  <= 1'b0;
            tile_done <= 1'b0;
        end else begin
            of_wr_en  <= q_valid;
            tile_done <= q_valid && q_pos.tile_last;
        end
    end

    always_ff @(posedge clock) begin
        if (q_valid) begin
            of_wr_addr <= pixel_addr;
            of_wr_data <= q_vec;
        end
    end

endmodule

// ==== logic/dla_core.sv ====
`timescale 1ns/100ps

module dla_core import dla_pkg::*; #(
    parameter int SIZE     = 8,
    parameter int DATA_WID = 16,
    parameter int ACC_WID  = 40
) (
    input  logic                          clock,
    input  logic                          rst,

    // Tile configuration
    input  logic                          tile_start,
    input  logic [DIM_WID-1:0]            tile_length,
    input  logic [DIM_WID-1:0]            tile_height,
    input  logic [DEPTH_WID-1:0]          valid_num,
    input  logic [SHIFT_WID-1:0]          qtf_shift,
    input  logic [SIZE-1:0][DATA_WID-1:0] bias,
    output logic                          busy,

    // Beats
    input  logic                          beat_valid,
    input  logic signed [DATA_WID-1:0]    ifm_pixel,
    input  logic [SIZE-1:0][DATA_WID-1:0] wgt_vec,

    // Global output buffer
    input  logic [ADDR_WID-1:0]           of_base_addr,
    input  logic [ADDR_WID-1:0]           of_page_length,
    output logic                          of_wr_en,
    output logic [ADDR_WID-1:0]           of_wr_addr,
    output logic [SIZE-1:0][DATA_WID-1:0] of_wr_data,
    output logic                          tile_done
);

    tile_cfg_t                     cfg;
    mac_cmd_t                      cmd;
    logic signed [DATA_WID-1:0]    cmd_pixel;
    logic [SIZE-1:0][DATA_WID-1:0] cmd_wgt;

    logic                          psum_valid;
    logic [SIZE-1:0][ACC_WID-1:0]  psum_vec;
    pixel_pos_t                    psum_pos;

    logic                          q_valid;
    logic [SIZE-1:0][DATA_WID-1:0] q_vec;
    pixel_pos_t                    q_pos;

    tile_sequencer #(.SIZE(SIZE), .DATA_WID(DATA_WID)) u_tile_sequencer (
        .clock       (clock),
        .rst         (rst),
        .tile_start  (tile_start),
        .tile_length (tile_length),
        .tile_height (tile_height),
        .valid_num   (valid_num),
        .qtf_shift   (qtf_shift),
        .beat_valid  (beat_valid),
        .ifm_pixel   (ifm_pixel),
        .wgt_vec     (wgt_vec),
        .busy        (busy),
        .cfg         (cfg),
        .cmd         (cmd),
        .cmd_pixel   (cmd_pixel),
        .cmd_wgt     (cmd_wgt)
    );

    mac_row #(.SIZE(SIZE), .DATA_WID(DATA_WID), .ACC_WID(ACC_WID)) u_mac_row (
        .clock       (clock),
        .rst         (rst),
        .cmd         (cmd),
        .cmd_pixel   (cmd_pixel),
        .cmd_wgt     (cmd_wgt),
        .psum_valid  (psum_valid),
        .psum_vec    (psum_vec),
        .psum_pos    (psum_pos)
    );

    qtf_unit #(.SIZE(SIZE), .DATA_WID(DATA_WID), .ACC_WID(ACC_WID)) u_qtf_unit (
        .clock       (clock),
        .rst         (rst),
        .qtf_shift   (cfg.qtf_shift),
        .bias        (bias),
        .psum_valid  (psum_valid),
        .psum_vec    (psum_vec),
        .psum_pos    (psum_pos),
        .q_valid     (q_valid),
        .q_vec       (q_vec),
        .q_pos       (q_pos)
    );

    glb_writer #(.SIZE(SIZE), .DATA_WID(DATA_WID)) u_glb_writer (
        .clock          (clock),
        .rst            (rst),
        .of_base_addr   (of_base_addr),
        .of_page_length (of_page_length),
        .q_valid        (q_valid),
        .q_vec          (q_vec),
        .q_pos          (q_pos),
        .of_wr_en       (of_wr_en),
        .of_wr_addr     (of_wr_addr),
        .of_wr_data     (of_wr_data),
        .tile_done      (tile_done)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic rst
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Released a little after a rising edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #10 rst = 1'b0;
    end

endmodule

// ==== verif/tb_dla_core.sv ====
`timescale 1ns/100ps

module tb_dla_core import dla_pkg::*; ();

    localparam int SIZE        = 8;
    localparam int DATA_WID    = 16;
    localparam int ACC_WID     = 40;
    localparam int DRIVE_DLY   = 10;
    localparam int IDLE_LIMIT  = 1000;
    localparam int DRAIN_LIMIT = 200;
    localparam int SETTLE      = 12;

    typedef logic [SIZE-1:0][DATA_WID-1:0] lanes_t;

    typedef struct packed {
        logic [DATA_WID-1:0] pixel;
        lanes_t              wgt;
    } beat_t;

    typedef struct packed {
        logic [ADDR_WID-1:0] addr;
        lanes_t              data;
    } write_t;

    logic                       clock;
    logic                       rst;
    logic                       tile_start;
    logic [DIM_WID-1:0]         tile_length;
    logic [DIM_WID-1:0]         tile_height;
    logic [DEPTH_WID-1:0]       valid_num;
    logic [SHIFT_WID-1:0]       qtf_shift;
    lanes_t                     bias;
    logic                       busy;
    logic                       beat_valid;
    logic signed [DATA_WID-1:0] ifm_pixel;
    lanes_t                     wgt_vec;
    logic [ADDR_WID-1:0]        of_base_addr;
    logic [ADDR_WID-1:0]        of_page_length;
    logic                       of_wr_en;
    logic [ADDR_WID-1:0]        of_wr_addr;
    lanes_t                     of_wr_data;
    logic                       tile_done;

    // One tile record from the stimulus file
    string                cur_name;
    logic [DIM_WID-1:0]   cur_len;
    logic [DIM_WID-1:0]   cur_height;
    logic [DEPTH_WID-1:0] cur_vnum;
    logic [SHIFT_WID-1:0] cur_shift;
    logic [ADDR_WID-1:0]  cur_base;
    logic [ADDR_WID-1:0]  cur_page;
    logic                 cur_gaps;
    logic                 cur_restart;
    lanes_t               cur_bias;

    beat_t       beat_q[$];
    write_t      write_q[$];
    write_t      exp_q[$];
    int unsigned last_beat_q[$];

    int          fd;
    int unsigned cycle;
    int unsigned done_count;
    int unsigned value_errors;
    int unsigned other_errors;

    tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(10)) u_clock_gen (
        .clock (clock),
        .rst   (rst)
    );

    dla_core #(.SIZE(SIZE), .DATA_WID(DATA_WID), .ACC_WID(ACC_WID)) u_dut (
        .clock          (clock),
        .rst            (rst),
        .tile_start     (tile_start),
        .tile_length    (tile_length),
        .tile_height    (tile_height),
        .valid_num      (valid_num),
        .qtf_shift      (qtf_shift),
        .bias           (bias),
        .busy           (busy),
        .beat_valid     (beat_valid),
        .ifm_pixel      (ifm_pixel),
        .wgt_vec        (wgt_vec),
        .of_base_addr   (of_base_addr),
        .of_page_length (of_page_length),
        .of_wr_en       (of_wr_en),
        .of_wr_addr     (of_wr_addr),
        .of_wr_data     (of_wr_data),
        .tile_done      (tile_done)
    );

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    task automatic report_mismatch(input string test, input string what,
                                   input logic [127:0] expected, input logic [127:0] actual);
        $display("[FAIL] %s %s: expected %0h, actual %0h", test, what, expected, actual);
        value_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s: %s", cur_name, msg);
        other_errors++;
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DLY;
        tile_start = 1'b0;
        beat_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int unsigned waited;
        waited = 0;
        @(negedge clock);
        while (busy && waited < IDLE_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        assert (!busy) else report_problem("timed out waiting for the DUT to leave its tile");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus file parsing
    //////////////////////////////////////////////////////////////////////

    task automatic read_hex(output logic [31:0] value);
        int code;
        code = $fscanf(fd, "%h", value);
        assert (code == 1) else report_problem("stimulus file has a missing or bad field");
    endtask

    task automatic read_name(output string name);
        logic [8*32-1:0] word;
        int              code;
        code = $fscanf(fd, "%s", word);
        assert (code == 1) else report_problem("stimulus file has a missing test name");
        name = $sformatf("%0s", word);
    endtask

    task automatic read_lanes(output lanes_t lanes);
        logic [31:0] value;
        int          i;
        for (i = 0; i < SIZE; i++) begin
            read_hex(value);
            lanes[i] = value[DATA_WID-1:0];
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tile driver
    //////////////////////////////////////////////////////////////////////

    task automatic run_tile();
        int unsigned k;
        int unsigned gap;
        int unsigned waited;
        int unsigned n_beats;
        beat_t       b;
        n_beats = beat_q.size();
        wait_idle();
        next_cycle();
        of_base_addr   = cur_base;
        of_page_length = cur_page;
        bias           = cur_bias;
        tile_length    = cur_len;
        tile_height    = cur_height;
        valid_num      = cur_vnum;
        qtf_shift      = cur_shift;
        tile_start     = 1'b1;
        exp_q          = write_q;
        last_beat_q.delete();
        done_count     = 0;
        for (k = 0; k < n_beats; k++) begin
            if (cur_gaps && k > 0) begin
                gap = $urandom % 4;
                repeat (gap) next_cycle();
            end
            next_cycle();
            if (k == 0) begin
                assert (busy) else report_mismatch(cur_name, "busy after tile_start", 1, busy);
            end
            b          = beat_q[k];
            beat_valid = 1'b1;
            ifm_pixel  = b.pixel;
            wgt_vec    = b.wgt;
            if (cur_restart && k == n_beats / 2) begin
                // Mid-tile restart with a config that the DUT must ignore
                tile_start  = 1'b1;
                tile_length = cur_len + DIM_WID'(1);
                tile_height = cur_height + DIM_WID'(2);
                valid_num   = cur_vnum + DEPTH_WID'(1);
                qtf_shift   = cur_shift + SHIFT_WID'(3);
            end
            if (k % cur_vnum == cur_vnum - 1) begin
                last_beat_q.push_back(cycle + 1);
            end
        end
        next_cycle();
        assert (!busy) else report_mismatch(cur_name, "busy after final beat", 0, busy);
        waited = 0;
        while ((exp_q.size() > 0 || done_count == 0) && waited < DRAIN_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        assert (exp_q.size() == 0) else
            report_problem($sformatf("%0d expected writes never arrived", exp_q.size()));
        assert (done_count > 0) else
            report_problem("timed out waiting for tile_done");
        exp_q.delete();
        last_beat_q.delete();
        // Room for a stray second tile_done
        repeat (SETTLE) @(posedge clock);
        assert (done_count == 1) else report_mismatch(cur_name, "tile_done pulses", 1, done_count);
    endtask

    task automatic send_idle_beats(input int unsigned n);
        int unsigned i;
        wait_idle();
        cur_name = "idle_beats";
        for (i = 0; i < n; i++) begin
            next_cycle();
            assert (!busy) else report_mismatch(cur_name, "busy", 0, busy);
            beat_valid = 1'b1;
            ifm_pixel  = DATA_WID'(i + 7);
            wgt_vec    = {SIZE{DATA_WID'(3)}};
        end
        next_cycle();
        // A write from these beats would land inside this window
        repeat (SETTLE) @(posedge clock);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Write monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin : monitor
        write_t      want;
        int unsigned due;
        if (!rst) begin
            assert (!tile_done || of_wr_en) else report_problem("tile_done pulsed without a write");
            if (tile_done) begin
                done_count++;
            end
            if (of_wr_en) begin
                assert (exp_q.size() > 0) else
                    report_problem($sformatf("unexpected write to address %0h", of_wr_addr));
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    assert (of_wr_addr == want.addr) else
                        report_mismatch(cur_name, "address", want.addr, of_wr_addr);
                    assert (of_wr_data == want.data) else
                        report_mismatch(cur_name, $sformatf("data at %0h", want.addr),
                                        want.data, of_wr_data);
                    assert (tile_done == (exp_q.size() == 0)) else
                        report_mismatch(cur_name, "tile_done", exp_q.size() == 0, tile_done);
                    if (last_beat_q.size() > 0) begin
                        due = last_beat_q.pop_front();
                        assert (cycle - due == 4) else
                            report_mismatch(cur_name, "cycles after last beat", 4, cycle - due);
                    end
                end
            end
        end
    end

    initial begin : main
        logic [8*32-1:0]  token;
        logic [8*256-1:0] line;
        logic [31:0]      value;
        int               code;
        int unsigned      waited;
        bit               reading;
        tile_start     = 1'b0;
        tile_length    = '0;
        tile_height    = '0;
        valid_num      = '0;
        qtf_shift      = '0;
        bias           = '0;
        beat_valid     = 1'b0;
        ifm_pixel      = '0;
        wgt_vec        = '0;
        of_base_addr   = '0;
        of_page_length = '0;
        value_errors   = 0;
        other_errors   = 0;
        done_count     = 0;
        cur_name       = "reset";
        void'($urandom(32'h8dc6_ce09));

        waited = 0;
        while (rst && waited < 100) begin
            @(posedge clock);
            waited++;
        end
        assert (!rst) else report_problem("reset was never released");
        repeat (5) begin
            @(negedge clock);
            assert ({busy, of_wr_en, tile_done} == 3'b000) else
                report_mismatch(cur_name, "busy/of_wr_en/tile_done", 0,
                                {busy, of_wr_en, tile_done});
        end

        fd = $fopen("verif/dla_stimulus.txt", "r");
        assert (fd != 0) else report_problem("cannot open verif/dla_stimulus.txt");
        reading = (fd != 0);
        while (reading) begin
            code = $fscanf(fd, "%s", token);
            if (code != 1) begin
                reading = 1'b0;
            end else if (token == "#") begin
                code = $fgets(line, fd);
            end else if (token == "tile") begin
                read_name(cur_name);
                read_hex(value);
                cur_len = value[DIM_WID-1:0];
                read_hex(value);
                cur_height = value[DIM_WID-1:0];
                read_hex(value);
                cur_vnum = value[DEPTH_WID-1:0];
                read_hex(value);
                cur_shift = value[SHIFT_WID-1:0];
                read_hex(value);
                cur_base = value[ADDR_WID-1:0];
                read_hex(value);
                cur_page = value[ADDR_WID-1:0];
                read_hex(value);
                cur_gaps = value[0];
                read_hex(value);
                cur_restart = value[0];
                beat_q.delete();
                write_q.delete();
            end else if (token == "bias") begin
                read_lanes(cur_bias);
            end else if (token == "beat") begin
                beat_t b;
                read_hex(value);
                b.pixel = value[DATA_WID-1:0];
                read_lanes(b.wgt);
                beat_q.push_back(b);
            end else if (token == "write") begin
                write_t w;
                read_hex(value);
                w.addr = value[ADDR_WID-1:0];
                read_lanes(w.data);
                write_q.push_back(w);
            end else if (token == "end") begin
                run_tile();
            end else if (token == "replay") begin
                read_name(cur_name);
                read_hex(value);
                cur_gaps = value[0];
                read_hex(value);
                cur_restart = value[0];
                run_tile();
            end else if (token == "idle") begin
                read_hex(value);
                send_idle_beats(value);
            end else begin
                report_problem($sformatf("unknown stimulus keyword %0s", token));
                reading = 1'b0;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Error count: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== verif/dla_stimulus.txt ====
# tile name len height valid_num shift base page gaps restart | bias b0..b7
# beat ifm w0..w7 | write addr d0..d7 | end | replay name gaps restart | idle n   (all hex)
idle 6
tile basic 2 2 3 2 0100 0010 0 0
bias 0000 0004 0002 fff8 0001 0000 fffd 0064
beat 0003 0001 0002 ffff 0003 0000 fffc 0005 0010
beat 0005 0001 0002 ffff 0003 0000 fffc 0005 0010
beat ffff 0001 0002 ffff 0003 0000 fffc 0005 0010
beat 000a 0001 0002 ffff 0003 0000 fffc 0005 0010
beat ffec 0001 0002 ffff 0003 0000 fffc 0005 0010
beat 0004 0001 0002 ffff 0003 0000 fffc 0005 0010
beat 0000 0001 0002 ffff 0003 0000 fffc 0005 0010
beat 0000 0001 0002 ffff 0003 0000 fffc 0005 0010
beat 0001 0001 0002 ffff 0003 0000 fffc 0005 0010
beat 0064 0001 0002 ffff 0003 0000 fffc 0005 0010
beat 00c8 0001 0002 ffff 0003 0000 fffc 0005 0010
beat ffce 0001 0002 ffff 0003 0000 fffc 0005 0010
write 0100 0001 0004 fffe 0003 0000 fff9 0008 0035
write 0101 fffe fffe 0002 fff9 0000 0006 fff7 0001
write 0110 0000 0001 0000 fffe 0000 ffff 0000 001d
write 0111 003e 007e ffc2 00b9 0000 ff06 0137 0401
end
replay gaps 1 0
replay restart 0 1
idle 4
tile saturate 1 2 2 4 0200 0040 0 0
bias 0000 0000 0000 0000 ffff 0000 0000 0000
beat 7fff 7fff 8000 ffff 0001 0000 0010 fff0 0100
beat 7fff 7fff 8000 ffff 0001 0000 0010 fff0 0100
beat 8000 7fff 8000 ffff 0001 0000 0010 fff0 0100
beat 8000 7fff 8000 ffff 0001 0000 0010 fff0 0100
write 0200 7fff 8000 f000 0fff ffff 7fff 8000 7fff
write 0240 8000 7fff 1000 f000 ffff 8000 7fff 8000
end

// ==== filelist.f ====
logic/dla_pkg.sv
logic/tile_sequencer.sv
logic/mac_row.sv
logic/qtf_unit.sv
logic/glb_writer.sv
logic/dla_core.sv
verif/tb_clock_gen.sv
verif/tb_dla_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dla_core -f filelist.f -o tb_dla_core_sim

./obj_dir/tb_dla_core_sim > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
